// File: ex_defines.svh
// opcode and result-group encodings for the execute stage
// codes must match the encoding used by the decode stage
// widths are fixed by the 32-bit MIPS ISA

`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

`define EX_WORD_W      32
`define EX_REG_ADDR_W  5
`define EX_ALUOP_W     8
`define EX_ALUSEL_W    3

// operation codes
`define EX_OP_NOP      8'b0000_0000
`define EX_OP_AND      8'b0010_0100
`define EX_OP_OR       8'b0010_0101
`define EX_OP_XOR      8'b0010_0110
`define EX_OP_NOR      8'b0010_0111
`define EX_OP_SLL      8'b0111_1100
`define EX_OP_SRL      8'b0000_0010
`define EX_OP_SRA      8'b0000_0011
`define EX_OP_ADD      8'b0010_0000
`define EX_OP_ADDU     8'b0010_0001
`define EX_OP_SUB      8'b0010_0010
`define EX_OP_SUBU     8'b0010_0011
`define EX_OP_SLT      8'b0010_1010
`define EX_OP_SLTU     8'b0010_1011
`define EX_OP_CLZ      8'b1011_0000
`define EX_OP_CLO      8'b1011_0001
`define EX_OP_MUL      8'b1010_1001
`define EX_OP_MULT     8'b0001_1000
`define EX_OP_MULTU    8'b0001_1001
`define EX_OP_MADD     8'b1010_0110
`define EX_OP_MADDU    8'b1010_1000
`define EX_OP_MSUB     8'b1010_1010
`define EX_OP_MSUBU    8'b1010_1011
`define EX_OP_MFHI     8'b0001_0000
`define EX_OP_MFLO     8'b0001_0010
`define EX_OP_MTHI     8'b0001_0001
`define EX_OP_MTLO     8'b0001_0011

// result groups, picks which unit drives wdata
`define EX_SEL_NOP     3'b000
`define EX_SEL_LOGIC   3'b001
`define EX_SEL_SHIFT   3'b010
`define EX_SEL_MOVE    3'b011
`define EX_SEL_ARITH   3'b100
`define EX_SEL_MUL     3'b101

`endif

// File: ex_pkg.sv
// types shared by the execute stage units
// widths come from ex_defines.svh

`include "ex_defines.svh"

package ex_pkg;

    typedef logic [`EX_WORD_W-1:0]     word_t;
    typedef logic [2*`EX_WORD_W-1:0]   dword_t;    // product or hi/lo pair
    typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`EX_ALUOP_W-1:0]    aluop_t;
    typedef logic [`EX_ALUSEL_W-1:0]   alusel_t;

    // decoded op from the id/ex register, held as a level
    typedef struct packed {
        aluop_t    aluop;
        alusel_t   alusel;
        word_t     reg1;
        word_t     reg2;
        reg_addr_t wd;     // destination register
        logic      wreg;   // write enable
    } ex_req_t;

    // result toward the mem stage
    typedef struct packed {
        reg_addr_t wd;
        logic      wreg;
        word_t     wdata;
    } ex_wb_t;

    typedef struct packed {
        word_t hi;
        word_t lo;
    } hilo_t;

    // madd/msub sequencing
    typedef enum logic {
        ACC_IDLE,   // capture product, stall requested
        ACC_ADD     // fold captured value into hi/lo
    } acc_state_e;

endpackage

// File: ex_mult.sv
// 32x32 multiplier, combinational
// signed ops go through magnitudes and a final negate, unsigned multiply directly

`timescale 1ns/100ps
`include "ex_defines.svh"

module ex_mult (
    input  ex_pkg::ex_req_t req_i,
    output ex_pkg::dword_t  product_o
);

    logic           is_signed;
    logic           neg_result;
    ex_pkg::word_t  opa;
    ex_pkg::word_t  opb;
    ex_pkg::dword_t raw_product;

    assign is_signed = (req_i.aluop == `EX_OP_MUL)  || (req_i.aluop == `EX_OP_MULT) ||
                       (req_i.aluop == `EX_OP_MADD) || (req_i.aluop == `EX_OP_MSUB);

    // magnitudes for signed ops
    assign opa = (is_signed && req_i.reg1[31]) ? (~req_i.reg1 + 1'b1) : req_i.reg1;
    assign opb = (is_signed && req_i.reg2[31]) ? (~req_i.reg2 + 1'b1) : req_i.reg2;

    assign raw_product = ex_pkg::dword_t'(opa) * ex_pkg::dword_t'(opb);

    assign neg_result = is_signed && (req_i.reg1[31] ^ req_i.reg2[31]);

    assign product_o = neg_result ? (~raw_product + 64'd1) : raw_product;

endmodule

// File: ex_alu.sv
// single-cycle part of the execute stage, purely combinational
// shift amount is reg1[4:0] applied to reg2
// add and sub drop the register write on signed overflow, addu/subu never do
// mfhi/mflo read the hi/lo register contents, no forwarding

`timescale 1ns/100ps
`include "ex_defines.svh"

module ex_alu (
    input  ex_pkg::ex_req_t req_i,
    input  ex_pkg::dword_t  product_i,  // from ex_mult, low word for mul
    input  ex_pkg::hilo_t   hilo_i,
    output ex_pkg::ex_wb_t  wb_o
);

    ex_pkg::word_t reg1;
    ex_pkg::word_t reg2;
    ex_pkg::word_t reg2_mux;
    ex_pkg::word_t sum;
    logic          is_sub;
    logic          sum_ovf;
    logic          lt_signed;
    logic          reg1_lt_reg2;
    ex_pkg::word_t logic_res;
    ex_pkg::word_t shift_res;
    ex_pkg::word_t arith_res;
    ex_pkg::word_t move_res;

    // number of zeros above the first set bit, 32 for an all-zero word
    function automatic logic [5:0] lead_zeros(input ex_pkg::word_t w);
        logic [5:0] cnt;
        logic       found;
        cnt   = 6'd32;
        found = 1'b0;
        for (int i = `EX_WORD_W - 1; i >= 0; i--) begin
            if (w[i] && !found) begin
                cnt   = 6'(`EX_WORD_W - 1 - i);
                found = 1'b1;
            end
        end
        return cnt;
    endfunction

    assign reg1 = req_i.reg1;
    assign reg2 = req_i.reg2;

    // slt reuses the subtractor
    assign is_sub = (req_i.aluop == `EX_OP_SUB) || (req_i.aluop == `EX_OP_SUBU) ||
                    (req_i.aluop == `EX_OP_SLT);

    assign reg2_mux = is_sub ? (~reg2 + 1'b1) : reg2;
    assign sum      = reg1 + reg2_mux;

    // overflow from the sign of the real second operand, so 0x8000_0000 is handled
    assign sum_ovf = (reg1[31] == (reg2[31] ^ is_sub)) && (sum[31] != reg1[31]);

    // same signs cannot overflow on subtract, sum sign is then the answer
    assign lt_signed = (reg1[31] && !reg2[31]) ||
                       ((reg1[31] == reg2[31]) && sum[31]);

    assign reg1_lt_reg2 = (req_i.aluop == `EX_OP_SLT) ? lt_signed : (reg1 < reg2);

    always_comb begin
        logic_res = '0;
        case (req_i.aluop)
            `EX_OP_AND: logic_res = reg1 & reg2;
            `EX_OP_OR:  logic_res = reg1 | reg2;
            `EX_OP_XOR: logic_res = reg1 ^ reg2;
            `EX_OP_NOR: logic_res = ~(reg1 | reg2);
            default:    logic_res = '0;
        endcase
    end

    always_comb begin
        shift_res = '0;
        case (req_i.aluop)
            `EX_OP_SLL: shift_res = reg2 << reg1[4:0];
            `EX_OP_SRL: shift_res = reg2 >> reg1[4:0];
            `EX_OP_SRA: shift_res = $signed(reg2) >>> reg1[4:0];  // fill with reg2[31]
            default:    shift_res = '0;
        endcase
    end

    always_comb begin
        arith_res = '0;
        case (req_i.aluop)
            `EX_OP_SLT,
            `EX_OP_SLTU: arith_res = {31'b0, reg1_lt_reg2};
            `EX_OP_ADD,
            `EX_OP_ADDU,
            `EX_OP_SUB,
            `EX_OP_SUBU: arith_res = sum;
            `EX_OP_CLZ:  arith_res = {26'b0, lead_zeros(reg1)};
            `EX_OP_CLO:  arith_res = {26'b0, lead_zeros(~reg1)};  // leading ones = zeros of inverse
            default:     arith_res = '0;
        endcase
    end

    always_comb begin
        move_res = '0;
        case (req_i.aluop)
            `EX_OP_MFHI: move_res = hilo_i.hi;
            `EX_OP_MFLO: move_res = hilo_i.lo;
            default:     move_res = '0;
        endcase
    end

    // result select and write control
    always_comb begin
        wb_o.wd = req_i.wd;
        if (((req_i.aluop == `EX_OP_ADD) || (req_i.aluop == `EX_OP_SUB)) && sum_ovf) begin
            wb_o.wreg = 1'b0;   // trap case, no register write
        end else begin
            wb_o.wreg = req_i.wreg;
        end

        case (req_i.alusel)
            `EX_SEL_LOGIC: wb_o.wdata = logic_res;
            `EX_SEL_SHIFT: wb_o.wdata = shift_res;
            `EX_SEL_ARITH: wb_o.wdata = arith_res;
            `EX_SEL_MUL:   wb_o.wdata = product_i[`EX_WORD_W-1:0];
            `EX_SEL_MOVE:  wb_o.wdata = move_res;
            default:       wb_o.wdata = '0;
        endcase
    end

endmodule

// File: ex_hilo_acc.sv
// hi/lo register pair plus the two-cycle madd/msub sequencer
// writes land at the next rising edge, mfhi/mflo see them a cycle later
// upstream must hold req_i while stall_req_o is high
// the second accumulate cycle adds unconditionally, req_i is assumed still held

`timescale 1ns/100ps
`include "ex_defines.svh"

module ex_hilo_acc (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  ex_pkg::ex_req_t req_i,
    input  ex_pkg::dword_t  product_i,   // sign corrected already
    output ex_pkg::hilo_t   hilo_o,
    output logic            stall_req_o
);

    ex_pkg::hilo_t      hilo_q;
    ex_pkg::dword_t     acc_q;      // captured product, negated for msub
    ex_pkg::acc_state_e state_q;
    ex_pkg::dword_t     hilo_sum;
    logic               is_madd;
    logic               is_msub;
    logic               is_acc;

    assign is_madd = (req_i.aluop == `EX_OP_MADD) || (req_i.aluop == `EX_OP_MADDU);
    assign is_msub = (req_i.aluop == `EX_OP_MSUB) || (req_i.aluop == `EX_OP_MSUBU);
    assign is_acc  = is_madd || is_msub;

    assign hilo_sum = {hilo_q.hi, hilo_q.lo} + acc_q;   // wraps mod 2^64

    // stall only while capturing
    assign stall_req_o = is_acc && (state_q == ex_pkg::ACC_IDLE);

    assign hilo_o = hilo_q;

    // accumulate state and captured operand
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ex_pkg::ACC_IDLE;
            acc_q   <= '0;
        end else begin
            case (state_q)
                ex_pkg::ACC_IDLE: begin
                    if (is_acc) begin
                        acc_q   <= is_msub ? (~product_i + 64'd1) : product_i;
                        state_q <= ex_pkg::ACC_ADD;
                    end
                end
                ex_pkg::ACC_ADD: begin
                    state_q <= ex_pkg::ACC_IDLE;   // one-cycle stall only
                end
            endcase
        end
    end

    // hi/lo write rules
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hilo_q <= '0;
        end else if (state_q == ex_pkg::ACC_ADD) begin
            hilo_q <= ex_pkg::hilo_t'(hilo_sum);
        end else begin
            case (req_i.aluop)
                `EX_OP_MULT,
                `EX_OP_MULTU: hilo_q    <= ex_pkg::hilo_t'(product_i);
                `EX_OP_MTHI:  hilo_q.hi <= req_i.reg1;   // lo untouched
                `EX_OP_MTLO:  hilo_q.lo <= req_i.reg1;   // hi untouched
                default: begin
                    hilo_q <= hilo_q;
                end
            endcase
        end
    end

endmodule

// File: ex_stage.sv
// execute stage of a five-stage MIPS-style pipeline
// req_i is a level from id/ex, wb_o follows it combinationally
// hi/lo lives here, so later stages do not forward it
// stall_req_o is high for exactly one cycle per madd/maddu/msub/msubu

`timescale 1ns/100ps

module ex_stage (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  ex_pkg::ex_req_t req_i,
    output ex_pkg::ex_wb_t  wb_o,
    output logic            stall_req_o
);

    ex_pkg::dword_t product;
    ex_pkg::hilo_t  hilo;

    ex_mult u_mult (
        .req_i     (req_i),
        .product_o (product)
    );

    ex_hilo_acc u_hilo_acc (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_i       (req_i),
        .product_i   (product),
        .hilo_o      (hilo),
        .stall_req_o (stall_req_o)
    );

    ex_alu u_alu (
        .req_i     (req_i),
        .product_i (product),
        .hilo_i    (hilo),    // registered contents, not bypassed
        .wb_o      (wb_o)
    );

endmodule

// File: tb_ex_stage.sv
// testbench for the execute stage, driven as a level on req_i
// inputs change 5 ns after the rising edge, outputs sampled 10 ns before the next one
// hi/lo expectations come from a model kept here, updated per instruction rules

`timescale 1ns/100ps
`include "ex_defines.svh"

module tb_ex_stage;

    logic            clk_i;
    logic            arst_n_i;
    ex_pkg::ex_req_t req;
    ex_pkg::ex_wb_t  wb;
    logic            stall;

    ex_pkg::word_t   rng_state;
    ex_pkg::dword_t  model_hilo;    // expected hi/lo pair
    ex_pkg::aluop_t  ls_ops [7];
    ex_pkg::aluop_t  arith_ops [6];
    ex_pkg::aluop_t  acc_ops [4];
    ex_pkg::word_t   fixed_a [6];   // overflow corner cases
    ex_pkg::word_t   fixed_b [6];
    int              test_errs;
    int              total_errs;
    int              tests_run;
    int              tests_failed;
    int              checks_run;

    ex_stage uut (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_i       (req),
        .wb_o        (wb),
        .stall_req_o (stall)
    );

    always #50 clk_i = ~clk_i;

    function automatic ex_pkg::word_t next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic ex_pkg::word_t expected_logic_shift(input ex_pkg::aluop_t op,
                                                           input ex_pkg::word_t a,
                                                           input ex_pkg::word_t b);
        int            sh;
        ex_pkg::word_t fill;
        sh   = int'(a[4:0]);
        fill = b[31] ? ~(32'hffff_ffff >> sh) : 32'd0;   // sign copies for sra
        case (op)
            `EX_OP_AND: return a & b;
            `EX_OP_OR:  return a | b;
            `EX_OP_XOR: return a ^ b;
            `EX_OP_NOR: return ~(a | b);
            `EX_OP_SLL: return b << sh;
            `EX_OP_SRL: return b >> sh;
            `EX_OP_SRA: return (b >> sh) | fill;
            default:    return 32'd0;
        endcase
    endfunction

    function automatic ex_pkg::word_t expected_arith(input ex_pkg::aluop_t op,
                                                     input ex_pkg::word_t a,
                                                     input ex_pkg::word_t b);
        case (op)
            `EX_OP_ADD,
            `EX_OP_ADDU: return a + b;
            `EX_OP_SUB,
            `EX_OP_SUBU: return a - b;
            `EX_OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `EX_OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:     return 32'd0;
        endcase
    endfunction

    // true when a trapping add/sub leaves the 32-bit signed range
    function automatic logic signed_overflow(input ex_pkg::aluop_t op,
                                             input ex_pkg::word_t a,
                                             input ex_pkg::word_t b);
        logic [32:0] wide;
        if (op == `EX_OP_ADD) begin
            wide = {a[31], a} + {b[31], b};
        end else if (op == `EX_OP_SUB) begin
            wide = {a[31], a} - {b[31], b};
        end else begin
            return 1'b0;
        end
        return wide[32] != wide[31];
    endfunction

    function automatic int lead_count(input ex_pkg::word_t w, input logic bit_val);
        int n;
        n = 0;
        while (n < 32 && w[31 - n] == bit_val) begin
            n++;
        end
        return n;
    endfunction

    function automatic ex_pkg::dword_t signed_product(input ex_pkg::word_t a,
                                                      input ex_pkg::word_t b);
        logic signed [63:0] p;
        p = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        return p;
    endfunction

    function automatic ex_pkg::dword_t unsigned_product(input ex_pkg::word_t a,
                                                        input ex_pkg::word_t b);
        return {32'd0, a} * {32'd0, b};
    endfunction

    task automatic check_val(input string name, input ex_pkg::word_t exp_v,
                             input ex_pkg::word_t act_v);
        checks_run++;
        assert (act_v === exp_v) else begin
            $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
            test_errs++;
        end
    endtask

    // one op per cycle, returns 10 ns before the next edge
    task automatic apply(input ex_pkg::aluop_t op, input ex_pkg::alusel_t sel,
                         input ex_pkg::word_t a, input ex_pkg::word_t b, input logic we);
        ex_pkg::word_t rnd;
        rnd = next_rand();
        @(posedge clk_i);
        #5;
        req.aluop  = op;
        req.alusel = sel;
        req.reg1   = a;
        req.reg2   = b;
        req.wd     = rnd[4:0];
        req.wreg   = we;
        #85;
    endtask

    task automatic check_hilo();
        apply(`EX_OP_MFHI, `EX_SEL_MOVE, next_rand(), next_rand(), 1'b1);
        check_val("wdata (mfhi)", model_hilo[63:32], wb.wdata);
        apply(`EX_OP_MFLO, `EX_SEL_MOVE, next_rand(), next_rand(), 1'b1);
        check_val("wdata (mflo)", model_hilo[31:0], wb.wdata);
    endtask

    // req stays held while stalled
    task automatic wait_stall_clear(output int cycles);
        cycles = 0;
        do begin
            @(posedge clk_i);
            #90;
            cycles++;
        end while (stall && cycles < 20);
        if (stall) begin
            $display("stall request still high after 20 cycles at %0t ns", $time);
            test_errs++;
        end
    endtask

    task automatic close_test(input string name);
        $display("test %-16s %0d error(s)", name, test_errs);
        tests_run++;
        if (test_errs != 0) begin
            tests_failed++;
        end
        total_errs += test_errs;
        test_errs = 0;
    endtask

    initial begin
        ex_pkg::word_t  a;
        ex_pkg::word_t  b;
        ex_pkg::word_t  w;
        ex_pkg::dword_t prod;
        logic           we;
        int             cycles;

        clk_i        = 1'b0;
        arst_n_i     = 1'b0;
        req          = '0;   // nop with wreg low
        rng_state    = 32'd74;
        model_hilo   = '0;
        test_errs    = 0;
        total_errs   = 0;
        tests_run    = 0;
        tests_failed = 0;
        checks_run   = 0;
        ls_ops    = '{`EX_OP_AND, `EX_OP_OR, `EX_OP_XOR, `EX_OP_NOR,
                      `EX_OP_SLL, `EX_OP_SRL, `EX_OP_SRA};
        arith_ops = '{`EX_OP_ADD, `EX_OP_ADDU, `EX_OP_SUB, `EX_OP_SUBU,
                      `EX_OP_SLT, `EX_OP_SLTU};
        acc_ops   = '{`EX_OP_MADD, `EX_OP_MADDU, `EX_OP_MSUB, `EX_OP_MSUBU};
        fixed_a   = '{32'h7fff_ffff, 32'h8000_0000, 32'h8000_0000,
                      32'h0000_0000, 32'h7fff_ffff, 32'hffff_ffff};
        fixed_b   = '{32'h0000_0001, 32'hffff_ffff, 32'h0000_0001,
                      32'h8000_0000, 32'h7fff_ffff, 32'h8000_0000};

        repeat (8) @(posedge clk_i);
        #5;
        arst_n_i = 1'b1;

        apply(`EX_OP_NOP, `EX_SEL_NOP, 32'd0, 32'd0, 1'b0);
        check_val("stall_req_o", 32'd0, 32'(stall));
        check_hilo();
        close_test("reset");

        for (int i = 0; i < 40; i++) begin
            a = next_rand();
            b = next_rand();
            for (int k = 0; k < 7; k++) begin
                we = b[k];   // vary the write enable
                apply(ls_ops[k], (k < 4) ? `EX_SEL_LOGIC : `EX_SEL_SHIFT, a, b, we);
                check_val("wdata", expected_logic_shift(ls_ops[k], a, b), wb.wdata);
                check_val("wd", 32'(req.wd), 32'(wb.wd));
                check_val("wreg", 32'(we), 32'(wb.wreg));
            end
        end
        close_test("logic/shift");

        for (int i = 0; i < 36; i++) begin
            a = (i < 6) ? fixed_a[i] : next_rand();
            b = (i < 6) ? fixed_b[i] : next_rand();
            for (int k = 0; k < 6; k++) begin
                apply(arith_ops[k], `EX_SEL_ARITH, a, b, 1'b1);
                check_val("wdata", expected_arith(arith_ops[k], a, b), wb.wdata);
                check_val("wreg", 32'(!signed_overflow(arith_ops[k], a, b)), 32'(wb.wreg));
            end
        end
        close_test("add/sub/slt");

        for (int i = 0; i < 54; i++) begin
            if (i == 0) begin
                w = 32'd0;
            end else if (i == 1) begin
                w = 32'hffff_ffff;
            end else if (i < 34) begin
                w = 32'd1 << (i - 2);   // single set bit
            end else begin
                w = next_rand();
            end
            apply(`EX_OP_CLZ, `EX_SEL_ARITH, w, next_rand(), 1'b1);
            check_val("wdata (clz)", 32'(lead_count(w, 1'b0)), wb.wdata);
            apply(`EX_OP_CLO, `EX_SEL_ARITH, w, next_rand(), 1'b1);
            check_val("wdata (clo)", 32'(lead_count(w, 1'b1)), wb.wdata);
        end
        close_test("clz/clo");

        for (int i = 0; i < 20; i++) begin
            a = next_rand();
            b = next_rand();
            prod = signed_product(a, b);
            apply(`EX_OP_MUL, `EX_SEL_MUL, a, b, 1'b1);
            check_val("wdata (mul)", prod[31:0], wb.wdata);
            apply(`EX_OP_MULT, `EX_SEL_NOP, a, b, 1'b0);
            model_hilo = prod;
            check_hilo();
            apply(`EX_OP_MULTU, `EX_SEL_NOP, a, b, 1'b0);
            model_hilo = unsigned_product(a, b);
            check_hilo();
            w = next_rand();
            apply(`EX_OP_MTHI, `EX_SEL_NOP, w, next_rand(), 1'b0);
            model_hilo[63:32] = w;
            check_hilo();
            w = next_rand();
            apply(`EX_OP_MTLO, `EX_SEL_NOP, w, next_rand(), 1'b0);
            model_hilo[31:0] = w;
            check_hilo();
        end
        close_test("mul/hilo");

        for (int k = 0; k < 4; k++) begin
            for (int r = 0; r < 5; r++) begin
                apply(`EX_OP_MTHI, `EX_SEL_NOP, next_rand(), 32'd0, 1'b0);
                model_hilo[63:32] = req.reg1;
                apply(`EX_OP_MTLO, `EX_SEL_NOP, next_rand(), 32'd0, 1'b0);
                model_hilo[31:0] = req.reg1;
                a = next_rand();
                b = next_rand();
                // odd entries are the unsigned forms
                prod = (k % 2 == 0) ? signed_product(a, b) : unsigned_product(a, b);
                apply(acc_ops[k], `EX_SEL_NOP, a, b, 1'b0);
                check_val("stall_req_o", 32'd1, 32'(stall));
                wait_stall_clear(cycles);
                assert (cycles == 1) else begin
                    $display("stall request lasted %0d cycles instead of one", cycles);
                    test_errs++;
                end
                model_hilo = (k < 2) ? model_hilo + prod : model_hilo - prod;
                check_hilo();
            end
        end
        close_test("madd/msub");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks_run, total_errs);
        if (total_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+.
ex_pkg.sv
ex_mult.sv
ex_alu.sv
ex_hilo_acc.sv
ex_stage.sv
tb_ex_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ex_stage -f project.f -o sim_ex_stage

./obj_dir/sim_ex_stage > sim.log 2>&1
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "Everything OK" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
